// ==== src/video_pkg.sv ====
package video_pkg;

    // ====================================================================
    // pixel and pair payloads
    // ====================================================================

    // one pixel, red on top
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_rgb_t;

    // earlier pixel sits in hi
    typedef struct packed {
        pixel_rgb_t hi;
        pixel_rgb_t lo;
    } pixel_pair_t;

    // per-slot sync flags, all active high
    typedef struct packed {
        logic hs;
        logic vs;
        logic de;
        logic fid;
    } pair_flags_t;

    // ====================================================================
    // osd overlay
    // ====================================================================

    typedef logic [1:0] osd_color_t;

    // indexed by osd_color_t, entry 0 at the right
    localparam pixel_rgb_t [3:0] OSD_PALETTE = {
        24'hffffff,     // white
        24'hffff00,     // yellow
        24'h0000ff,     // blue
        24'h000000      // black
    };

endpackage

// ==== src/ctrl_pkg.sv ====
package ctrl_pkg;

    // ====================================================================
    // system control word
    // ====================================================================

    localparam int SYS_CTRL_W = 32;

    // bit positions inside sys_ctrl
    localparam int HSYNC_POL_BIT  = 8;
    localparam int VSYNC_POL_BIT  = 9;
    localparam int FRAMELOCK_BIT  = 14;
    localparam int VIP_SELECT_BIT = 15;

    // fields kept after decode
    typedef struct packed {
        logic hsync_pol;     // capture hsync polarity
        logic vsync_pol;     // capture vsync polarity
        logic framelock;
        logic vip_select;    // 1 = output from external processor
    } ctrl_fields_t;

    // ====================================================================
    // board inputs
    // ====================================================================

    localparam int KEY_W = 2;   // push buttons

endpackage

// ==== src/video_stream_if.sv ====
`timescale 1ns/1ns

// one pixel per clk27 with syncs in raw sense
interface video_stream_if;

    video_pkg::pixel_rgb_t rgb;
    logic                  hs;
    logic                  vs;
    logic                  de;

    modport src (
        output rgb,
        output hs,
        output vs,
        output de
    );

    modport snk (
        input rgb,
        input hs,
        input vs,
        input de
    );

endinterface

// ==== src/ctrl_decode.sv ====
`timescale 1ns/1ns

module ctrl_decode #(
    parameter int LED_HOLD_CYCLES = 16_777_215
) (
    input  logic                            clk27,
    input  logic                            sys_reset_n,
    input  logic [ctrl_pkg::SYS_CTRL_W-1:0] sys_ctrl_i,
    input  logic [ctrl_pkg::KEY_W-1:0]      key_i,
    input  logic                            resync_strobe_i,
    output ctrl_pkg::ctrl_fields_t          ctrl_o,
    output logic [ctrl_pkg::KEY_W-1:0]      buttons_o,
    output logic [1:0]                      led_o
);

    localparam int CTR_W = (LED_HOLD_CYCLES > 1) ? $clog2(LED_HOLD_CYCLES + 1) : 1;
    localparam logic [CTR_W-1:0] HOLD_LOAD = CTR_W'(LED_HOLD_CYCLES);

    logic [ctrl_pkg::KEY_W-1:0] btn_sync1;
    logic                       resync_sync1;
    logic                       resync_sync2;
    logic                       resync_prev;
    logic                       resync_rise;
    logic [CTR_W-1:0]           resync_led_ctr;

    // ====================================================================
    // control word fields
    // ====================================================================

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            ctrl_o <= '0;
        end else begin
            ctrl_o.hsync_pol  <= sys_ctrl_i[ctrl_pkg::HSYNC_POL_BIT];
            ctrl_o.vsync_pol  <= sys_ctrl_i[ctrl_pkg::VSYNC_POL_BIT];
            ctrl_o.framelock  <= sys_ctrl_i[ctrl_pkg::FRAMELOCK_BIT];
            ctrl_o.vip_select <= sys_ctrl_i[ctrl_pkg::VIP_SELECT_BIT];
        end
    end

    // ====================================================================
    // synchronizers
    // ====================================================================

    // buttons idle high
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            btn_sync1 <= '1;
            buttons_o <= '1;
        end else begin
            btn_sync1 <= key_i;
            buttons_o <= btn_sync1;
        end
    end

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            resync_sync1 <= 1'b0;
            resync_sync2 <= 1'b0;
            resync_prev  <= 1'b0;
        end else begin
            resync_sync1 <= resync_strobe_i;
            resync_sync2 <= resync_sync1;
            resync_prev  <= resync_sync2;   // for edge detect
        end
    end

    assign resync_rise = resync_sync2 & ~resync_prev;

    // led stretcher, a new edge restarts the hold time
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            resync_led_ctr <= '0;
        end else if (resync_rise) begin
            resync_led_ctr <= HOLD_LOAD;
        end else if (resync_led_ctr != '0) begin
            resync_led_ctr <= resync_led_ctr - 1'b1;
        end
    end

    assign led_o = {(resync_led_ctr != '0), ctrl_o.framelock};

endmodule

// ==== src/pixel_pair_pack.sv ====
`timescale 1ns/1ns

module pixel_pair_pack (
    input  logic                   clk27,
    input  logic                   sys_reset_n,
    input  ctrl_pkg::ctrl_fields_t ctrl_i,
    input  video_pkg::pixel_rgb_t  cap_rgb_i,
    input  logic                   cap_hsync_i,
    input  logic                   cap_vsync_i,
    input  logic                   cap_de_i,
    input  logic                   cap_fid_i,
    input  logic                   cap_valid_i,
    output video_pkg::pixel_pair_t pair_o,
    output video_pkg::pair_flags_t flags_hi_o,
    output video_pkg::pair_flags_t flags_lo_o,
    output logic                   pair_valid_o
);

    video_pkg::pair_flags_t cap_flags;
    logic                   phase_lo;   // next accepted pixel goes to lo slot

    // bring syncs to active high whatever the source polarity
    always_comb begin
        cap_flags.hs  = ~(cap_hsync_i ^ ctrl_i.hsync_pol);
        cap_flags.vs  = ~(cap_vsync_i ^ ctrl_i.vsync_pol);
        cap_flags.de  = cap_de_i;
        cap_flags.fid = ~cap_fid_i;
    end

    // ====================================================================
    // pair phase and strobe
    // ====================================================================

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            phase_lo     <= 1'b0;
            pair_valid_o <= 1'b0;
        end else begin
            pair_valid_o <= cap_valid_i & phase_lo;
            if (cap_valid_i) begin
                phase_lo <= ~phase_lo;
            end
        end
    end

    // ====================================================================
    // slot registers
    // ====================================================================

    always_ff @(posedge clk27) begin
        if (cap_valid_i) begin
            if (!phase_lo) begin
                pair_o.hi  <= cap_rgb_i;
                flags_hi_o <= cap_flags;
            end else begin
                pair_o.lo  <= cap_rgb_i;
                flags_lo_o <= cap_flags;
            end
        end
    end

endmodule

// ==== src/pixel_pair_unpack.sv ====
`timescale 1ns/1ns

module pixel_pair_unpack (
    input  logic                   clk27,
    input  logic                   sys_reset_n,
    input  video_pkg::pixel_pair_t pair_i,
    input  video_pkg::pair_flags_t flags_hi_i,
    input  video_pkg::pair_flags_t flags_lo_i,
    input  logic                   pair_valid_i,
    video_stream_if.src            stream
);

    logic                   lo_pending;
    video_pkg::pixel_rgb_t  lo_rgb;      // held for the second cycle
    video_pkg::pair_flags_t lo_flags;

    // ====================================================================
    // slot sequencing and syncs
    // ====================================================================

    // a fresh pair always wins over a pending lo pixel
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            lo_pending <= 1'b0;
            stream.hs  <= 1'b0;
            stream.vs  <= 1'b0;
            stream.de  <= 1'b0;
        end else if (pair_valid_i) begin
            lo_pending <= 1'b1;
            stream.hs  <= ~flags_hi_i.hs;   // back to raw sense
            stream.vs  <= ~flags_hi_i.vs;
            stream.de  <= flags_hi_i.de;
        end else if (lo_pending) begin
            lo_pending <= 1'b0;
            stream.hs  <= ~lo_flags.hs;
            stream.vs  <= ~lo_flags.vs;
            stream.de  <= lo_flags.de;
        end
    end

    // ====================================================================
    // pixel data
    // ====================================================================

    always_ff @(posedge clk27) begin
        if (pair_valid_i) begin
            stream.rgb <= pair_i.hi;
            lo_rgb     <= pair_i.lo;
            lo_flags   <= flags_lo_i;
        end else if (lo_pending) begin
            stream.rgb <= lo_rgb;
        end
    end

endmodule

// ==== src/tx_output_stage.sv ====
`timescale 1ns/1ns

module tx_output_stage (
    input  logic                   clk27,
    input  logic                   sys_reset_n,
    input  ctrl_pkg::ctrl_fields_t ctrl_i,
    video_stream_if.snk            sc_stream,
    video_stream_if.snk            vip_stream,
    input  logic                   osd_enable_i,
    input  video_pkg::osd_color_t  osd_color_i,
    output video_pkg::pixel_rgb_t  tx_d_o,
    output logic                   tx_hs_o,
    output logic                   tx_vs_o,
    output logic                   tx_de_o
);

    video_pkg::pixel_rgb_t src_rgb;
    logic                  src_hs;
    logic                  src_vs;
    logic                  src_de;

    video_pkg::pixel_rgb_t out_rgb;
    logic                  out_hs;
    logic                  out_vs;
    logic                  out_de;

    // source select, osd colour replaces pixel data only
    always_comb begin
        if (ctrl_i.vip_select) begin
            src_rgb = vip_stream.rgb;
            src_hs  = vip_stream.hs;
            src_vs  = vip_stream.vs;
            src_de  = vip_stream.de;
        end else begin
            src_rgb = sc_stream.rgb;
            src_hs  = sc_stream.hs;
            src_vs  = sc_stream.vs;
            src_de  = sc_stream.de;
        end
        if (osd_enable_i) begin
            src_rgb = video_pkg::OSD_PALETTE[osd_color_i];
        end
    end

    // ====================================================================
    // stage 1
    // ====================================================================

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            out_hs <= 1'b0;
            out_vs <= 1'b0;
            out_de <= 1'b0;
        end else begin
            out_hs <= src_hs;
            out_vs <= src_vs;
            out_de <= src_de;
        end
    end

    always_ff @(posedge clk27) begin
        out_rgb <= src_rgb;
        tx_d_o  <= out_rgb;     // stage 2 data
    end

    // ====================================================================
    // stage 2, transmitter pins
    // ====================================================================

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            tx_hs_o <= 1'b0;
            tx_vs_o <= 1'b0;
            tx_de_o <= 1'b0;
        end else begin
            tx_hs_o <= out_hs;
            tx_vs_o <= out_vs;
            tx_de_o <= out_de;
        end
    end

endmodule

// ==== src/isl_video_top.sv ====
`timescale 1ns/1ns

module isl_video_top #(
    parameter int LED_HOLD_CYCLES = 16_777_215
) (
    input  logic                            clk27,
    input  logic                            sys_reset_n,

    // control
    input  logic [ctrl_pkg::SYS_CTRL_W-1:0] sys_ctrl_i,
    input  logic [ctrl_pkg::KEY_W-1:0]      key_i,
    input  logic                            resync_strobe_i,

    // digitizer capture
    input  video_pkg::pixel_rgb_t           cap_rgb_i,
    input  logic                            cap_hsync_i,
    input  logic                            cap_vsync_i,
    input  logic                            cap_de_i,
    input  logic                            cap_fid_i,
    input  logic                            cap_valid_i,

    // to and from the video processor
    output video_pkg::pixel_pair_t          vip_pair_o,
    output video_pkg::pair_flags_t          vip_flags_hi_o,
    output video_pkg::pair_flags_t          vip_flags_lo_o,
    output logic                            vip_pair_valid_o,
    input  video_pkg::pixel_pair_t          vip_pair_i,
    input  video_pkg::pair_flags_t          vip_flags_hi_i,
    input  video_pkg::pair_flags_t          vip_flags_lo_i,
    input  logic                            vip_pair_valid_i,

    // scan converter
    input  video_pkg::pixel_rgb_t           sc_rgb_i,
    input  logic                            sc_hsync_i,
    input  logic                            sc_vsync_i,
    input  logic                            sc_de_i,

    input  logic                            osd_enable_i,
    input  video_pkg::osd_color_t           osd_color_i,

    // transmitter and board
    output video_pkg::pixel_rgb_t           tx_d_o,
    output logic                            tx_hs_o,
    output logic                            tx_vs_o,
    output logic                            tx_de_o,
    output logic [1:0]                      led_o,
    output logic [ctrl_pkg::KEY_W-1:0]      buttons_o
);

    ctrl_pkg::ctrl_fields_t ctrl;

    video_stream_if vip_stream ();
    video_stream_if sc_stream ();

    assign sc_stream.rgb = sc_rgb_i;
    assign sc_stream.hs  = sc_hsync_i;
    assign sc_stream.vs  = sc_vsync_i;
    assign sc_stream.de  = sc_de_i;

    ctrl_decode #(
        .LED_HOLD_CYCLES(LED_HOLD_CYCLES)
    ) u_ctrl_decode (
        .clk27          (clk27),
        .sys_reset_n    (sys_reset_n),
        .sys_ctrl_i     (sys_ctrl_i),
        .key_i          (key_i),
        .resync_strobe_i(resync_strobe_i),
        .ctrl_o         (ctrl),
        .buttons_o      (buttons_o),
        .led_o          (led_o)
    );

    pixel_pair_pack u_pack (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .ctrl_i      (ctrl),
        .cap_rgb_i   (cap_rgb_i),
        .cap_hsync_i (cap_hsync_i),
        .cap_vsync_i (cap_vsync_i),
        .cap_de_i    (cap_de_i),
        .cap_fid_i   (cap_fid_i),
        .cap_valid_i (cap_valid_i),
        .pair_o      (vip_pair_o),
        .flags_hi_o  (vip_flags_hi_o),
        .flags_lo_o  (vip_flags_lo_o),
        .pair_valid_o(vip_pair_valid_o)
    );

    pixel_pair_unpack u_unpack (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .pair_i      (vip_pair_i),
        .flags_hi_i  (vip_flags_hi_i),
        .flags_lo_i  (vip_flags_lo_i),
        .pair_valid_i(vip_pair_valid_i),
        .stream      (vip_stream.src)
    );

    tx_output_stage u_tx_out (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .ctrl_i      (ctrl),
        .sc_stream   (sc_stream.snk),
        .vip_stream  (vip_stream.snk),
        .osd_enable_i(osd_enable_i),
        .osd_color_i (osd_color_i),
        .tx_d_o      (tx_d_o),
        .tx_hs_o     (tx_hs_o),
        .tx_vs_o     (tx_vs_o),
        .tx_de_o     (tx_de_o)
    );

endmodule

// ==== test/tb_isl_video_ref.svh ====
`ifndef TB_ISL_VIDEO_REF_SVH
`define TB_ISL_VIDEO_REF_SVH

// ======================================================================
// expected values for the pixel path
// ======================================================================

function automatic logic [23:0] osd_rgb(input logic [1:0] color);
    case (color)
        2'd0:    return 24'h000000;   // black
        2'd1:    return 24'h0000ff;   // blue, low byte only
        2'd2:    return 24'hffff00;   // yellow
        default: return 24'hffffff;
    endcase
endfunction

// raw capture {hsync, vsync, de, fid} to active high flags
function automatic logic [3:0] norm_flags(input logic [3:0] raw, input logic hpol,
                                          input logic vpol);
    return {~(raw[3] ^ hpol), ~(raw[2] ^ vpol), raw[1], ~raw[0]};
endfunction

// tx word {rgb, hs, vs, de} for one scan converter pixel
function automatic logic [26:0] sc_tx(input logic [26:0] sc, input logic osd_en,
                                      input logic [1:0] color);
    if (osd_en) begin
        return {osd_rgb(color), sc[2:0]};
    end
    return sc;
endfunction

// one slot of a returned pair, syncs back to raw sense
function automatic logic [26:0] returned_tx(input logic [23:0] rgb, input logic [3:0] flags);
    return {rgb, ~flags[3], ~flags[2], flags[1]};
endfunction

`endif

// ==== test/tb_isl_video.sv ====
`timescale 1ns/1ns

module tb_isl_video;

    localparam int KIND_TX   = 0;
    localparam int KIND_BTN  = 1;
    localparam int KIND_LED0 = 2;
    localparam int KIND_PAIR = 3;

    logic        clk27;
    logic        sys_reset_n;
    logic        resync_strobe_i, cap_hsync_i, cap_vsync_i, cap_de_i, cap_fid_i, cap_valid_i;
    logic        vip_pair_valid_i, sc_hsync_i, sc_vsync_i, sc_de_i, osd_enable_i;
    logic [31:0] sys_ctrl_i;
    logic [1:0]  osd_color_i;
    logic [23:0] cap_rgb_i;
    logic [23:0] sc_rgb_i;
    logic [47:0] vip_pair_i;
    logic [3:0]  vip_flags_hi_i;
    logic [3:0]  vip_flags_lo_i;
    logic [ctrl_pkg::KEY_W-1:0] key_i;
    logic [ctrl_pkg::KEY_W-1:0] buttons_o;
    logic [47:0] vip_pair_o;
    logic [3:0]  vip_flags_hi_o;
    logic [3:0]  vip_flags_lo_o;
    logic        vip_pair_valid_o, tx_hs_o, tx_vs_o, tx_de_o;
    logic [23:0] tx_d_o;
    logic [1:0]  led_o;

    int          cyc = 0;
    int          checks = 0;
    int          val_errs = 0;
    int          other_errs = 0;
    integer      seed = 43;
    int          due_q[$];      // cycle each expected value falls due
    int          kind_q[$];
    logic [55:0] exp_q[$];

    `include "tb_isl_video_ref.svh"

    isl_video_top #(.LED_HOLD_CYCLES(64)) dut0 (.*);

    initial begin
        clk27 = 1'b0;
        forever #4 clk27 = ~clk27;
    end

    always @(posedge clk27) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] make_ctrl(input logic hpol, input logic vpol,
                                              input logic lock, input logic vip);
        logic [31:0] word;
        word = '0;
        word[ctrl_pkg::HSYNC_POL_BIT]  = hpol;
        word[ctrl_pkg::VSYNC_POL_BIT]  = vpol;
        word[ctrl_pkg::FRAMELOCK_BIT]  = lock;
        word[ctrl_pkg::VIP_SELECT_BIT] = vip;
        return word;
    endfunction

    task automatic compare_value(input string sig, input logic [55:0] exp,
                                 input logic [55:0] act);
        checks++;
        if (act !== exp) begin
            val_errs++;
            $display("ERR t=%0t %s expected %0h actual %0h", $time, sig, exp, act);
        end
    endtask

    // called right after a rising edge, stages counted from the next edge
    task automatic push_expect(input int kind, input int stages, input logic [55:0] exp);
        due_q.push_back(cyc + 1 + stages);
        kind_q.push_back(kind);
        exp_q.push_back(exp);
    endtask

    task automatic drain_expected();
        int n;
        n = 0;
        while (due_q.size() != 0 && n < 20) begin
            @(negedge clk27);
            n++;
        end
        if (due_q.size() != 0) begin
            other_errs++;
            $display("timeout: %0d expected values never came due", due_q.size());
            due_q.delete();
            kind_q.delete();
            exp_q.delete();
        end
    endtask

    task automatic drive_sc_cycle(input logic osd_en, input logic [1:0] color);
        logic [26:0] sc;
        sc = 27'($random(seed));    // {rgb, hs, vs, de}
        @(posedge clk27);
        {sc_rgb_i, sc_hsync_i, sc_vsync_i, sc_de_i} <= sc;
        osd_enable_i <= osd_en;
        osd_color_i  <= color;
        push_expect(KIND_TX, 2, 56'(sc_tx(sc, osd_en, color)));
    endtask

    // ==================================================================
    // compare process, outputs sampled on the falling edge
    // ==================================================================

    always @(negedge clk27) begin : compare_outputs
        logic pair_due;
        pair_due = 1'b0;
        for (int i = due_q.size() - 1; i >= 0; i--) begin
            if (due_q[i] == cyc) begin
                case (kind_q[i])
                    KIND_TX:   compare_value("{tx_d_o,tx_hs_o,tx_vs_o,tx_de_o}", exp_q[i],
                                             56'({tx_d_o, tx_hs_o, tx_vs_o, tx_de_o}));
                    KIND_BTN:  compare_value("buttons_o", exp_q[i], 56'(buttons_o));
                    KIND_LED0: compare_value("led_o[0]", exp_q[i], 56'(led_o[0]));
                    default: begin
                        pair_due = 1'b1;
                        compare_value("{vip_pair_o,vip_flags_hi_o,vip_flags_lo_o}", exp_q[i],
                                      {vip_pair_o, vip_flags_hi_o, vip_flags_lo_o});
                    end
                endcase
                due_q.delete(i);
                kind_q.delete(i);
                exp_q.delete(i);
            end
        end
        if (sys_reset_n === 1'b1) begin
            compare_value("vip_pair_valid_o", 56'(pair_due), 56'(vip_pair_valid_o));
        end
    end

    // ==================================================================
    // stimulus
    // ==================================================================

    initial begin : stimulus
        int          n;
        int          gap;
        int          elapsed;
        logic [23:0] rgb;
        logic [23:0] hi_rgb;
        logic [3:0]  raw;
        logic [3:0]  hi_flags;
        logic [3:0]  lo_flags;
        logic [47:0] pair;
        logic        valid;
        logic        phase;
        logic [ctrl_pkg::KEY_W-1:0] keys;

        sys_reset_n = 1'b0;
        {sys_ctrl_i, key_i, resync_strobe_i, cap_rgb_i, cap_hsync_i, cap_vsync_i, cap_de_i,
         cap_fid_i, cap_valid_i, vip_pair_i, vip_flags_hi_i, vip_flags_lo_i, vip_pair_valid_i,
         sc_rgb_i, sc_hsync_i, sc_vsync_i, sc_de_i, osd_enable_i, osd_color_i} = '0;

        @(posedge clk27);
        @(negedge clk27);           // still in reset
        compare_value("buttons_o", 56'({ctrl_pkg::KEY_W{1'b1}}), 56'(buttons_o));
        compare_value("led_o", 56'(0), 56'(led_o));
        compare_value("tx_de_o", 56'(0), 56'(tx_de_o));
        @(posedge clk27);
        sys_reset_n <= 1'b1;

        for (n = 0; n < 20; n++) begin
            keys = ctrl_pkg::KEY_W'($random(seed));
            @(posedge clk27);
            key_i <= keys;
            push_expect(KIND_BTN, 2, 56'(keys));
        end

        // scan converter path, then each osd colour
        for (n = 0; n < 40; n++) begin
            drive_sc_cycle(1'b0, 2'd0);
        end
        for (n = 0; n < 32; n++) begin
            drive_sc_cycle(1'b1, 2'(n / 8));
        end
        drive_sc_cycle(1'b0, 2'd0);
        drain_expected();

        // pair packing under all four sync polarities
        phase = 1'b0;
        for (int pol = 0; pol < 4; pol++) begin
            @(posedge clk27);
            sys_ctrl_i <= make_ctrl(pol[0], pol[1], 1'b0, 1'b0);
            repeat (2) @(posedge clk27);
            n = 0;
            for (int accepted = 0; accepted < 12 && n < 100; n++) begin
                valid = ({$random(seed)} % 4) != 0;
                rgb   = 24'($random(seed));
                raw   = 4'($random(seed));      // hsync, vsync, de, fid
                @(posedge clk27);
                cap_valid_i <= valid;
                cap_rgb_i   <= rgb;
                {cap_hsync_i, cap_vsync_i, cap_de_i, cap_fid_i} <= raw;
                if (valid) begin
                    lo_flags = norm_flags(raw, pol[0], pol[1]);
                    if (phase) begin
                        push_expect(KIND_PAIR, 1, {hi_rgb, rgb, hi_flags, lo_flags});
                    end
                    hi_rgb   = rgb;
                    hi_flags = lo_flags;
                    phase    = ~phase;
                    accepted++;
                end
            end
            @(posedge clk27);
            cap_valid_i <= 1'b0;
            drain_expected();
        end

        // returned pairs through the processor stream
        @(posedge clk27);
        sys_ctrl_i <= make_ctrl(1'b0, 1'b0, 1'b0, 1'b1);
        repeat (3) @(posedge clk27);
        for (n = 0; n < 20; n++) begin
            pair     = 48'({$random(seed), $random(seed)});
            hi_flags = 4'($random(seed));
            lo_flags = 4'($random(seed));
            gap      = 2 + ({$random(seed)} % 4);
            @(posedge clk27);
            {vip_pair_i, vip_flags_hi_i, vip_flags_lo_i} <= {pair, hi_flags, lo_flags};
            vip_pair_valid_i <= 1'b1;
            push_expect(KIND_TX, 3, 56'(returned_tx(pair[47:24], hi_flags)));
            push_expect(KIND_TX, 4, 56'(returned_tx(pair[23:0], lo_flags)));
            @(posedge clk27);
            vip_pair_valid_i <= 1'b0;
            vip_pair_i       <= 48'({$random(seed), $random(seed)});   // junk between pulses
            vip_flags_lo_i   <= 4'($random(seed));
            repeat (gap - 2) @(posedge clk27);
        end
        drain_expected();

        // framelock led, then the resync stretcher
        @(posedge clk27);
        sys_ctrl_i <= make_ctrl(1'b0, 1'b0, 1'b1, 1'b0);
        push_expect(KIND_LED0, 1, 56'(1'b1));
        @(posedge clk27);
        sys_ctrl_i <= '0;
        push_expect(KIND_LED0, 1, 56'(1'b0));
        drain_expected();
        @(posedge clk27);
        resync_strobe_i <= 1'b1;
        elapsed = 0;
        @(negedge clk27);
        while (led_o[1] !== 1'b1 && elapsed < 5) begin
            @(negedge clk27);
            elapsed++;
        end
        if (led_o[1] !== 1'b1) begin
            other_errs++;
            $display("resync LED did not come on within 5 cycles of the strobe edge");
        end
        while (elapsed < 60) begin
            @(negedge clk27);
            elapsed++;
        end
        compare_value("led_o[1]", 56'(1'b1), 56'(led_o[1]));
        while (led_o[1] !== 1'b0 && elapsed < 72) begin
            @(negedge clk27);
            elapsed++;
        end
        if (led_o[1] !== 1'b0) begin
            other_errs++;
            $display("resync LED still on 72 cycles after the strobe edge");
        end
        @(posedge clk27);
        resync_strobe_i <= 1'b0;
        drain_expected();

        $display("checks %0d, value errors %0d, other failures %0d", checks, val_errs,
                 other_errs);
        if (val_errs == 0 && other_errs == 0 && checks > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+test
src/video_pkg.sv
src/ctrl_pkg.sv
src/video_stream_if.sv
src/ctrl_decode.sv
src/pixel_pair_pack.sv
src/pixel_pair_unpack.sv
src/tx_output_stage.sv
src/isl_video_top.sv
test/tb_isl_video.sv
